// ==== rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // ================================================
    // Machine sizes
    // ================================================
    localparam int lanes     = 2;
    localparam int arch_regs = 32;
    localparam int phys_regs = 48;
    localparam int arch_w    = 5;
    localparam int phys_w    = 6;

    // ================================================
    // Instruction class
    // ================================================
    typedef enum logic [2:0] {
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_cas
    } op_e;

    // ================================================
    // Renamed instruction as handed to dispatch
    // ================================================
    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [31:0]       pc;
        // Physical operands read as zero when unused or x0
        logic [phys_w-1:0] prs1;
        logic [phys_w-1:0] prs2;
        logic [phys_w-1:0] prd;
        logic              rs1_valid;
        logic              rs2_valid;
        logic              rd_valid;
        // Kept so commit can retire the mapping later
        logic [arch_w-1:0] arch_rd;
    } lane_t;

endpackage

`default_nettype wire

// ==== map_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface map_if import rename_pkg::*; ();

    // Source lookups, answered from the speculative map
    logic [lanes-1:0][arch_w-1:0] arch_rs1;
    logic [lanes-1:0][arch_w-1:0] arch_rs2;
    logic [lanes-1:0][phys_w-1:0] phys_rs1;
    logic [lanes-1:0][phys_w-1:0] phys_rs2;

    // Destination writes, applied at the accept edge
    logic [lanes-1:0]             wr_en;
    logic [lanes-1:0][arch_w-1:0] wr_arch;
    logic [lanes-1:0][phys_w-1:0] wr_phys;

    modport stage (
        output arch_rs1, arch_rs2, wr_en, wr_arch, wr_phys,
        input  phys_rs1, phys_rs2
    );

    modport tbl (
        input  arch_rs1, arch_rs2, wr_en, wr_arch, wr_phys,
        output phys_rs1, phys_rs2
    );

endinterface

`default_nettype wire

// ==== alloc_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface alloc_if import rename_pkg::*; ();

    logic [lanes-1:0]             req;
    logic [lanes-1:0]             grant;
    logic [lanes-1:0][phys_w-1:0] phys;
    // Consumes the granted register at the next edge
    logic [lanes-1:0]             take;

    modport stage (
        output req, take,
        input  grant, phys
    );

    modport list (
        input  req, take,
        output grant, phys
    );

endinterface

`default_nettype wire

// ==== free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module free_list import rename_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    alloc_if.list                        alloc,
    input  logic [lanes-1:0]             commit_en,
    input  logic [lanes-1:0][phys_w-1:0] commit_phys_rd,
    input  logic [lanes-1:0]             release_en,
    input  logic [lanes-1:0][phys_w-1:0] release_phys,
    input  logic                         flush
);

    logic [phys_regs-1:0] free_q;
    logic [phys_regs-1:0] free_d;
    // Registers held by the committed map
    logic [phys_regs-1:0] used_q;
    logic [phys_regs-1:0] used_d;
    logic [phys_regs-1:0] upper_free;
    logic [phys_w-1:0]    pick0;
    logic [phys_w-1:0]    pick1;

    function automatic logic [phys_w-1:0] lowest_set(input logic [phys_regs-1:0] vec);
        logic [phys_w-1:0] idx;
        idx = '0;
        for (int i = phys_regs - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = phys_w'(i);
            end
        end
        return idx;
    endfunction

    // ================================================
    // Grant search
    // ================================================
    always_comb begin
        pick0 = lowest_set(free_q);
        // Lane 1 searches above lane 0's pick only when lane 0 asked
        for (int i = 0; i < phys_regs; i++) begin
            upper_free[i] = free_q[i] && (!alloc.req[0] || (i > int'(pick0)));
        end
        pick1 = lowest_set(upper_free);
        alloc.phys[0]  = pick0;
        alloc.phys[1]  = pick1;
        alloc.grant[0] = alloc.req[0] && (|free_q);
        alloc.grant[1] = alloc.req[1] && (|upper_free);
    end

    // ================================================
    // Bookkeeping
    // ================================================
    always_comb begin
        free_d = free_q;
        used_d = used_q;
        for (int i = 0; i < lanes; i++) begin
            if (alloc.take[i]) begin
                free_d[alloc.phys[i]] = 1'b0;
            end
            if (commit_en[i]) begin
                used_d[commit_phys_rd[i]] = 1'b1;
            end
        end
        // Releases last, so a same-cycle commit that is superseded gets freed
        for (int i = 0; i < lanes; i++) begin
            if (release_en[i]) begin
                used_d[release_phys[i]] = 1'b0;
                free_d[release_phys[i]] = 1'b1;
            end
        end
        if (flush) begin
            free_d = ~used_d;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            used_q <= {{(phys_regs - arch_regs){1'b0}}, {arch_regs{1'b1}}};
            free_q <= {{(phys_regs - arch_regs){1'b1}}, {arch_regs{1'b0}}};
        end else begin
            used_q <= used_d;
            free_q <= free_d;
        end
    end

    a_take_distinct: assert property (@(posedge clk) disable iff (reset)
        (&alloc.take) |-> (alloc.phys[0] != alloc.phys[1]));

    for (genvar i = 0; i < lanes; i++) begin : g_chk
        a_release_not_free: assert property (@(posedge clk) disable iff (reset)
            release_en[i] |-> !free_q[release_phys[i]]);
        a_no_zero_grant: assert property (@(posedge clk) disable iff (reset)
            alloc.grant[i] |-> (alloc.phys[i] != '0));
    end

endmodule

`default_nettype wire

// ==== rename_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_table import rename_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    map_if.tbl                           map,
    input  logic [lanes-1:0]             commit_en,
    input  logic [lanes-1:0][arch_w-1:0] commit_arch_rd,
    input  logic [lanes-1:0][phys_w-1:0] commit_phys_rd,
    output logic [lanes-1:0]             release_en,
    output logic [lanes-1:0][phys_w-1:0] release_phys,
    input  logic                         flush
);

    logic [phys_w-1:0] spec_map [arch_regs];
    logic [phys_w-1:0] com_map  [arch_regs];
    logic [phys_w-1:0] com_next [arch_regs];

    // ================================================
    // Source lookups
    // ================================================
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            map.phys_rs1[i] = spec_map[map.arch_rs1[i]];
            map.phys_rs2[i] = spec_map[map.arch_rs2[i]];
        end
    end

    // ================================================
    // Commit and release
    // ================================================
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            // x0 is never remapped
            release_en[i]   = commit_en[i] && (commit_arch_rd[i] != '0);
            release_phys[i] = com_map[commit_arch_rd[i]];
            // An older lane of the same group retiring this register
            // holds the mapping that is really being replaced
            for (int j = 0; j < i; j++) begin
                if (release_en[j] && (commit_arch_rd[j] == commit_arch_rd[i])) begin
                    release_phys[i] = commit_phys_rd[j];
                end
            end
        end
    end

    always_comb begin
        com_next = com_map;
        for (int i = 0; i < lanes; i++) begin
            if (release_en[i]) begin
                com_next[commit_arch_rd[i]] = commit_phys_rd[i];
            end
        end
    end

    // ================================================
    // Map state
    // ================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Identity map out of reset
            for (int r = 0; r < arch_regs; r++) begin
                spec_map[r] <= phys_w'(r);
                com_map[r]  <= phys_w'(r);
            end
        end else begin
            com_map <= com_next;
            if (flush) begin
                // Includes the commits of this same cycle
                spec_map <= com_next;
            end else begin
                // Later lanes win on the same architectural register
                for (int i = 0; i < lanes; i++) begin
                    if (map.wr_en[i]) begin
                        spec_map[map.wr_arch[i]] <= map.wr_phys[i];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rename_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_stage import rename_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [lanes-1:0]             dec_valid,
    input  op_e  [lanes-1:0]             dec_op,
    input  logic [lanes-1:0][31:0]       dec_pc,
    input  logic [lanes-1:0][arch_w-1:0] dec_rs1,
    input  logic [lanes-1:0]             dec_rs1_valid,
    input  logic [lanes-1:0][arch_w-1:0] dec_rs2,
    input  logic [lanes-1:0]             dec_rs2_valid,
    input  logic [lanes-1:0][arch_w-1:0] dec_rd,
    input  logic [lanes-1:0]             dec_rd_valid,
    output logic                         rename_ready,
    output lane_t [lanes-1:0]            out_lane,
    input  logic                         flush,
    map_if.stage                         map,
    alloc_if.stage                       alloc
);

    // Lanes that need a fresh physical register
    logic [lanes-1:0]  need;
    logic              accept;
    lane_t [lanes-1:0] next_lane;

    // ================================================
    // Allocation and back-pressure
    // ================================================
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            need[i] = dec_valid[i] && dec_rd_valid[i] && (dec_rd[i] != '0);
        end
    end

    // The bundle goes only when every request in it is granted
    assign rename_ready = !flush && ((need & alloc.grant) == need);
    assign accept       = rename_ready && (|dec_valid);

    assign alloc.req  = need;
    assign alloc.take = accept ? need : '0;

    assign map.arch_rs1 = dec_rs1;
    assign map.arch_rs2 = dec_rs2;
    assign map.wr_en    = accept ? need : '0;
    assign map.wr_arch  = dec_rd;
    assign map.wr_phys  = alloc.phys;

    // ================================================
    // Operand mapping
    // ================================================
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            next_lane[i].valid     = dec_valid[i];
            next_lane[i].op        = dec_op[i];
            next_lane[i].pc        = dec_pc[i];
            next_lane[i].rs1_valid = dec_rs1_valid[i];
            next_lane[i].rs2_valid = dec_rs2_valid[i];
            next_lane[i].rd_valid  = need[i];
            next_lane[i].arch_rd   = dec_rd[i];
            next_lane[i].prd       = need[i] ? alloc.phys[i] : '0;
            next_lane[i].prs1      = map.phys_rs1[i];
            next_lane[i].prs2      = map.phys_rs2[i];

            // Older lane in the bundle writing our source
            for (int j = 0; j < i; j++) begin
                if (need[j] && (dec_rs1[i] == dec_rd[j])) begin
                    next_lane[i].prs1 = alloc.phys[j];
                end
                if (need[j] && (dec_rs2[i] == dec_rd[j])) begin
                    next_lane[i].prs2 = alloc.phys[j];
                end
            end

            if (!dec_rs1_valid[i] || (dec_rs1[i] == '0)) begin
                next_lane[i].prs1 = '0;
            end
            if (!dec_rs2_valid[i] || (dec_rs2[i] == '0)) begin
                next_lane[i].prs2 = '0;
            end
        end
    end

    // ================================================
    // Dispatch register
    // ================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_lane <= '0;
        end else if (accept) begin
            out_lane <= next_lane;
        end else begin
            // Stall, flush or empty bundle
            for (int i = 0; i < lanes; i++) begin
                out_lane[i].valid <= 1'b0;
            end
        end
    end

    for (genvar i = 0; i < lanes; i++) begin : g_chk
        a_flush_kills: assert property (@(posedge clk) disable iff (reset)
            flush |=> !out_lane[i].valid);
    end

endmodule

`default_nettype wire

// ==== rename_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_unit import rename_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    // Decode bundle
    input  logic [lanes-1:0]             dec_valid,
    input  op_e  [lanes-1:0]             dec_op,
    input  logic [lanes-1:0][31:0]       dec_pc,
    input  logic [lanes-1:0][arch_w-1:0] dec_rs1,
    input  logic [lanes-1:0]             dec_rs1_valid,
    input  logic [lanes-1:0][arch_w-1:0] dec_rs2,
    input  logic [lanes-1:0]             dec_rs2_valid,
    input  logic [lanes-1:0][arch_w-1:0] dec_rd,
    input  logic [lanes-1:0]             dec_rd_valid,
    // Renamed bundle
    output logic                         rename_ready,
    output logic [lanes-1:0]             rename_valid,
    output op_e  [lanes-1:0]             rename_op,
    output logic [lanes-1:0][31:0]       rename_pc,
    output logic [lanes-1:0][phys_w-1:0] rename_prs1,
    output logic [lanes-1:0][phys_w-1:0] rename_prs2,
    output logic [lanes-1:0][phys_w-1:0] rename_prd,
    output logic [lanes-1:0]             rename_rd_valid,
    output logic [lanes-1:0][arch_w-1:0] rename_arch_rd,
    // Retirement
    input  logic [lanes-1:0]             commit_en,
    input  logic [lanes-1:0][arch_w-1:0] commit_arch_rd,
    input  logic [lanes-1:0][phys_w-1:0] commit_phys_rd,
    input  logic                         flush_pipeline
);

    lane_t [lanes-1:0]            out_lane;
    logic [lanes-1:0]             release_en;
    logic [lanes-1:0][phys_w-1:0] release_phys;

    map_if   i_map ();
    alloc_if i_alloc ();

    rename_stage i_stage (
        .clk           (clk),
        .reset         (reset),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_pc        (dec_pc),
        .dec_rs1       (dec_rs1),
        .dec_rs1_valid (dec_rs1_valid),
        .dec_rs2       (dec_rs2),
        .dec_rs2_valid (dec_rs2_valid),
        .dec_rd        (dec_rd),
        .dec_rd_valid  (dec_rd_valid),
        .rename_ready  (rename_ready),
        .out_lane      (out_lane),
        .flush         (flush_pipeline),
        .map           (i_map.stage),
        .alloc         (i_alloc.stage)
    );

    rename_table i_table (
        .clk            (clk),
        .reset          (reset),
        .map            (i_map.tbl),
        .commit_en      (commit_en),
        .commit_arch_rd (commit_arch_rd),
        .commit_phys_rd (commit_phys_rd),
        .release_en     (release_en),
        .release_phys   (release_phys),
        .flush          (flush_pipeline)
    );

    free_list i_free_list (
        .clk            (clk),
        .reset          (reset),
        .alloc          (i_alloc.list),
        .commit_en      (commit_en),
        .commit_phys_rd (commit_phys_rd),
        .release_en     (release_en),
        .release_phys   (release_phys),
        .flush          (flush_pipeline)
    );

    for (genvar i = 0; i < lanes; i++) begin : g_out
        assign rename_valid[i]    = out_lane[i].valid;
        assign rename_op[i]       = out_lane[i].op;
        assign rename_pc[i]       = out_lane[i].pc;
        assign rename_prs1[i]     = out_lane[i].prs1;
        assign rename_prs2[i]     = out_lane[i].prs2;
        assign rename_prd[i]      = out_lane[i].prd;
        assign rename_rd_valid[i] = out_lane[i].rd_valid;
        assign rename_arch_rd[i]  = out_lane[i].arch_rd;
    end

endmodule

`default_nettype wire

// ==== tb_rename_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rename_unit import rename_pkg::*; ();

    localparam int n_steps = 16;
    localparam int n_cols  = 21;

    logic                         clk = 1'b0;
    logic                         reset;
    logic [lanes-1:0]             dec_valid;
    op_e  [lanes-1:0]             dec_op;
    logic [lanes-1:0][31:0]       dec_pc;
    logic [lanes-1:0][arch_w-1:0] dec_rs1;
    logic [lanes-1:0]             dec_rs1_valid;
    logic [lanes-1:0][arch_w-1:0] dec_rs2;
    logic [lanes-1:0]             dec_rs2_valid;
    logic [lanes-1:0][arch_w-1:0] dec_rd;
    logic [lanes-1:0]             dec_rd_valid;
    logic                         rename_ready;
    logic [lanes-1:0]             rename_valid;
    op_e  [lanes-1:0]             rename_op;
    logic [lanes-1:0][31:0]       rename_pc;
    logic [lanes-1:0][phys_w-1:0] rename_prs1;
    logic [lanes-1:0][phys_w-1:0] rename_prs2;
    logic [lanes-1:0][phys_w-1:0] rename_prd;
    logic [lanes-1:0]             rename_rd_valid;
    logic [lanes-1:0][arch_w-1:0] rename_arch_rd;
    logic [lanes-1:0]             commit_en;
    logic [lanes-1:0][arch_w-1:0] commit_arch_rd;
    logic [lanes-1:0][phys_w-1:0] commit_phys_rd;
    logic                         flush_pipeline;

    // One row per cycle with the columns in groups
    //   dec_valid mask | lane 0 rs1 rs2 rd | lane 1 rs1 rs2 rd (-1 is an unused field)
    //   commit_en mask, arch0, phys0, arch1, phys1 | flush | rename_ready
    //   next-cycle rename_valid mask | lane 0 prs1 prs2 prd | lane 1 prs1 prs2 prd
    int tab [n_steps][n_cols];
    int step       = 0;
    int checks     = 0;
    int mismatches = 0;
    int timeouts   = 0;

    rename_unit i_dut (.*);

    always #4 clk = ~clk;

    // ================================================
    // Stimulus table
    // ================================================
    task automatic load_table();
        // Identity sources, fresh registers from 32 upward, in-bundle bypass
        tab[0]  = '{3, 1,2,5, 3,4,6, 0,0,0,0,0, 0, 1, 3, 1,2,32, 3,4,33};
        tab[1]  = '{3, 5,6,7, 7,0,0, 0,0,0,0,0, 0, 1, 3, 32,33,34, 34,0,0};
        tab[2]  = '{3, 0,-1,8, 8,5,9, 0,0,0,0,0, 0, 1, 3, 0,0,35, 35,32,36};
        // Drain the free list
        tab[3]  = '{3, 1,2,10, 3,4,11, 0,0,0,0,0, 0, 1, 3, 1,2,37, 3,4,38};
        tab[4]  = '{3, 10,11,12, 12,-1,13, 0,0,0,0,0, 0, 1, 3, 37,38,39, 39,0,40};
        tab[5]  = '{3, -1,-1,14, -1,-1,15, 0,0,0,0,0, 0, 1, 3, 0,0,41, 0,0,42};
        tab[6]  = '{3, -1,-1,16, -1,-1,17, 0,0,0,0,0, 0, 1, 3, 0,0,43, 0,0,44};
        tab[7]  = '{3, -1,-1,18, -1,-1,19, 0,0,0,0,0, 0, 1, 3, 0,0,45, 0,0,46};
        // Only 47 left, so the pair stalls while x5 commits to 32
        tab[8]  = '{3, 5,-1,20, -1,-1,21, 1,5,32,0,0, 0, 0, 0, 0,0,0, 0,0,0};
        tab[9]  = '{3, 5,-1,20, -1,-1,21, 0,0,0,0,0, 0, 1, 3, 32,0,5, 0,0,47};
        // Flush with a commit of x6 to 33 in the same cycle
        tab[10] = '{3, 6,7,22, -1,-1,23, 1,6,33,0,0, 1, 0, 0, 0,0,0, 0,0,0};
        tab[11] = '{3, 5,6,7, 7,8,9, 0,0,0,0,0, 0, 1, 3, 32,33,5, 5,8,6};
        // Both lanes retire x7, then 7 and 5 come back
        tab[12] = '{0, -1,-1,-1, -1,-1,-1, 3,7,5,7,6, 0, 1, 0, 0,0,0, 0,0,0};
        tab[13] = '{3, -1,-1,12, -1,-1,13, 0,0,0,0,0, 0, 1, 3, 0,0,5, 0,0,7};
        tab[14] = '{0, -1,-1,-1, -1,-1,-1, 0,0,0,0,0, 1, 0, 0, 0,0,0, 0,0,0};
        tab[15] = '{3, 7,5,11, 6,11,-1, 0,0,0,0,0, 0, 1, 3, 6,32,5, 33,5,0};
    endtask

    function automatic logic [arch_w-1:0] arch_idx(input int v);
        // Unused fields point at x31 so that zeroing is visible
        return (v < 0) ? arch_w'(31) : arch_w'(v);
    endfunction

    task automatic clear_inputs();
        for (int i = 0; i < lanes; i++) begin
            dec_op[i] = op_alu;
        end
        dec_valid      = '0;
        dec_pc         = '0;
        dec_rs1        = '0;
        dec_rs1_valid  = '0;
        dec_rs2        = '0;
        dec_rs2_valid  = '0;
        dec_rd         = '0;
        dec_rd_valid   = '0;
        commit_en      = '0;
        commit_arch_rd = '0;
        commit_phys_rd = '0;
        flush_pipeline = 1'b0;
    endtask

    task automatic drive_step(input int k);
        int base;
        for (int i = 0; i < lanes; i++) begin
            base = 1 + 3 * i;
            dec_valid[i]      = tab[k][0][i];
            dec_op[i]         = op_e'((k + i) % 5);
            dec_pc[i]         = $urandom;
            dec_rs1_valid[i]  = tab[k][base] >= 0;
            dec_rs1[i]        = arch_idx(tab[k][base]);
            dec_rs2_valid[i]  = tab[k][base + 1] >= 0;
            dec_rs2[i]        = arch_idx(tab[k][base + 1]);
            dec_rd_valid[i]   = tab[k][base + 2] >= 0;
            dec_rd[i]         = arch_idx(tab[k][base + 2]);
            commit_en[i]      = tab[k][7][i];
            commit_arch_rd[i] = arch_w'(tab[k][8 + 2 * i]);
            commit_phys_rd[i] = phys_w'(tab[k][9 + 2 * i]);
        end
        flush_pipeline = tab[k][12][0];
    endtask

    // ================================================
    // Checks
    // ================================================
    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] want);
        checks++;
        assert (got == want) else begin
            mismatches++;
            $display("Mismatch %s at step %0d: got 0x%h, expected 0x%h",
                     name, step, got, want);
        end
    endtask

    task automatic check_outputs(input int k);
        int base;
        for (int i = 0; i < lanes; i++) begin
            base = 15 + 3 * i;
            compare($sformatf("rename_valid[%0d]", i), rename_valid[i], tab[k][14][i]);
            if (tab[k][14][i]) begin
                compare($sformatf("rename_prs1[%0d]", i), rename_prs1[i], tab[k][base]);
                compare($sformatf("rename_prs2[%0d]", i), rename_prs2[i], tab[k][base + 1]);
                compare($sformatf("rename_prd[%0d]", i), rename_prd[i], tab[k][base + 2]);
                compare($sformatf("rename_rd_valid[%0d]", i), rename_rd_valid[i],
                        tab[k][base + 2] != 0);
                // Decode inputs still carry the bundle of step k here
                compare($sformatf("rename_pc[%0d]", i), rename_pc[i], dec_pc[i]);
                compare($sformatf("rename_op[%0d]", i), rename_op[i], (k + i) % 5);
                compare($sformatf("rename_arch_rd[%0d]", i), rename_arch_rd[i],
                        arch_idx(tab[k][3 + 3 * i]));
            end
        end
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!rename_ready && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (rename_ready) else begin
            timeouts++;
            $display("Timeout: rename_ready stayed low for %0d cycles after reset", limit);
        end
    endtask

    // ================================================
    // Main sequence
    // ================================================
    initial begin
        void'($urandom(64));
        reset = 1'b1;
        clear_inputs();
        load_table();
        repeat (2) @(negedge clk);
        reset = 1'b0;

        for (int k = 0; k < n_steps; k++) begin
            if (k > 0) begin
                @(negedge clk);
                check_outputs(k - 1);
            end
            step = k;
            drive_step(k);
            #1;
            if (k == 0) begin
                // Decode holds the first bundle until the free list offers registers
                wait_ready(20);
            end
            compare("rename_ready", rename_ready, tab[k][13]);
        end
        @(negedge clk);
        check_outputs(n_steps - 1);
        clear_inputs();

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_unit.f ====
rename_pkg.sv
map_if.sv
alloc_if.sv
free_list.sv
rename_table.sv
rename_stage.sv
rename_unit.sv
tb_rename_unit.sv

// ==== Bender.yml ====
package:
  name: rename_unit

sources:
  - rename_pkg.sv
  - map_if.sv
  - alloc_if.sv
  - free_list.sv
  - rename_table.sv
  - rename_stage.sv
  - rename_unit.sv
  - target: test
    files:
      - tb_rename_unit.sv
